/* compile.f */
src/cartBusPkg.sv
src/cartCfgPkg.sv
src/busStrobeDecoder.sv
src/protStreamDecrypt.sv
src/romReadArbiter.sv
src/stvCart.sv
sim/stvCart_asserts.sv
sim/tb_stvCart.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_stvCart
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= compile.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIMARGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_stvCart.sv */
`timescale 1ns/1ps

module tb_stvCart;
	import cartBusPkg::*;
	import cartCfgPkg::*;

	localparam logic [15:0] romPattern = 16'h5A3C;

	logic        CLK;
	logic        RST_N;
	logic        resN;
	gameMode_t   mode;
	logic        cs0N;
	logic        cs1N;
	logic        rdN;
	logic        wrlN;
	logic        wruN;
	logic [25:0] addr;
	logic [15:0] dataIn;
	logic        memRdy;
	logic [15:0] memDataIn;
	logic [15:0] aDataOut;
	logic        awaitN;
	logic        arqtN;
	logic [24:0] memAddr;
	logic        memRd;
	logic [24:0] lastAddr;
	int          seed = 32'hab6c;
	int          romMinDelay = 0;
	int          testErrors = 0;
	int          passCount = 0;
	int          failCount = 0;
	string       curTest;

	stvCart u_stvCart (.*);

	always #10 CLK = !CLK;

	function automatic logic [15:0] romWord(input logic [24:0] wordAddr);
		return wordAddr[15:0] ^ romPattern;
	endfunction

	// even stream words take the lower key half
	function automatic logic [15:0] streamWord(input logic [31:0] byteAddr, input int idx,
			input logic [31:0] key);
		logic [24:0] w;
		w = byteAddr[25:1] + 25'(idx);
		return romWord(w) ^ ((idx % 2 == 1) ? key[31:16] : key[15:0]);
	endfunction

	function automatic logic [25:0] regAddress(input logic [2:0] off);
		return {2'b00, protWindowBase + 23'(off), 1'b0};
	endfunction

	// ROM model answers after 0 to 5 cycles unless the request goes away
	always begin : romModel
		int delay;
		@(posedge CLK);
		#2;
		if (memRd) begin
			delay = $unsigned($random(seed)) % 6;
			// slow responses keep a prefetch in flight longer
			if (delay < romMinDelay)
				delay = romMinDelay;
			while (delay > 0 && memRd) begin
				@(posedge CLK);
				#2;
				delay--;
			end
			if (memRd) begin
				lastAddr = memAddr;
				memDataIn = romWord(memAddr);
				memRdy = 1'b1;
				@(posedge CLK);
				#2;
				memRdy = 1'b0;
			end
		end
	end

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("FAILED %s %s: expected %h, actual %h", curTest, what, expected, actual);
			testErrors++;
		end
	endtask

	// one A-bus cycle with the strobe held until the wait line is high
	task automatic busAccess(input logic isWrite, input logic useCs1, input logic [25:0] a,
			input logic [15:0] wd, output logic [15:0] rdValue);
		int waited;
		@(posedge CLK);
		#2;
		cs0N = useCs1;
		cs1N = !useCs1;
		addr = a;
		dataIn = wd;
		if (isWrite) begin
			wrlN = 1'b0;
			wruN = 1'b0;
		end else begin
			rdN = 1'b0;
		end
		// edge sampled and pulsed before the wait line is valid
		repeat (2) @(posedge CLK);
		waited = 0;
		@(negedge CLK);
		while (!awaitN && waited < 40) begin
			@(negedge CLK);
			waited++;
		end
		if (!awaitN) begin
			$display("test %s: timed out waiting for the wait line to rise", curTest);
			testErrors++;
		end
		rdValue = aDataOut;
		@(posedge CLK);
		#2;
		rdN = 1'b1;
		wrlN = 1'b1;
		wruN = 1'b1;
		cs0N = 1'b1;
		cs1N = 1'b1;
	endtask

	task automatic setStream(input logic [31:0] byteAddr);
		logic [15:0] ignored;
		busAccess(1'b1, 1'b1, regAddress(regAddrLo), byteAddr[15:0], ignored);
		busAccess(1'b1, 1'b1, regAddress(regAddrHi), byteAddr[31:16], ignored);
	endtask

	task automatic checkStream(input logic [31:0] byteAddr, input int idx);
		logic [15:0] got;
		busAccess(1'b0, 1'b1, regAddress(regData), 16'h0, got);
		checkValue($sformatf("stream word %0d", idx), streamWord(byteAddr, idx,
			keyForMode(mode)), got);
	endtask

	task automatic finishTest();
		if (testErrors == 0) begin
			$display("test %s: ok", curTest);
			passCount++;
		end else begin
			$display("test %s: %0d errors", curTest, testErrors);
			failCount++;
		end
		testErrors = 0;
	endtask

	initial begin
		logic [15:0] got;
		logic [31:0] rnd;
		logic [25:0] a;
		int waited;
		CLK = 1'b0;
		RST_N = 1'b0;
		resN = 1'b1;
		mode = 4'd0;
		cs0N = 1'b1;
		cs1N = 1'b1;
		rdN = 1'b1;
		wrlN = 1'b1;
		wruN = 1'b1;
		addr = '0;
		dataIn = '0;
		memRdy = 1'b0;
		memDataIn = '0;
		lastAddr = '0;
		repeat (3) @(posedge CLK);
		#2;
		RST_N = 1'b1;

		curTest = "direct_reads";
		for (int i = 0; i < 6; i++) begin
			rnd = $random(seed);
			a = {2'b00, rnd[23:1], 1'b0};
			busAccess(1'b0, i[0], a, 16'h0, got);
			checkValue("data", romWord({i[0], a[24:1]}), got);
			checkValue("memAddr", {i[0], a[24:1]}, lastAddr);
		end
		finishTest();

		curTest = "stream_mode3";
		mode = 4'd3;
		setStream(32'h0012_3456);
		for (int i = 0; i < 8; i++)
			checkStream(32'h0012_3456, i);
		finishTest();

		// odd phase when the restart arrives
		curTest = "stream_restart";
		setStream(32'h0004_0A10);
		checkStream(32'h0004_0A10, 0);
		setStream(32'h0156_7BC2);
		for (int i = 0; i < 4; i++)
			checkStream(32'h0156_7BC2, i);
		finishTest();

		curTest = "mode0_window";
		mode = 4'd0;
		a = regAddress(regData);
		busAccess(1'b0, 1'b1, a, 16'h0, got);
		checkValue("data", romWord({1'b1, a[24:1]}), got);
		finishTest();

		curTest = "read_during_prefetch";
		mode = 4'd3;
		// slow ROM so the prefetch is still pending at the direct read
		romMinDelay = 5;
		setStream(32'h0033_0008);
		rnd = $random(seed);
		a = {2'b00, rnd[23:1], 1'b0};
		busAccess(1'b0, 1'b0, a, 16'h0, got);
		checkValue("direct data", romWord({1'b0, a[24:1]}), got);
		checkStream(32'h0033_0008, 0);
		checkStream(32'h0033_0008, 1);
		romMinDelay = 0;
		finishTest();

		curTest = "board_reset";
		@(posedge CLK);
		#2;
		cs0N = 1'b0;
		addr = 26'h000_2468;
		rdN = 1'b0;
		waited = 0;
		@(negedge CLK);
		while (awaitN && waited < 20) begin
			@(negedge CLK);
			waited++;
		end
		if (awaitN) begin
			$display("test %s: the wait line never went low", curTest);
			testErrors++;
		end
		@(posedge CLK);
		#2;
		resN = 1'b0;
		rdN = 1'b1;
		cs0N = 1'b1;
		repeat (3) @(negedge CLK);
		checkValue("awaitN in reset", 32'd1, {31'd0, awaitN});
		checkValue("memRd in reset", 32'd0, {31'd0, memRd});
		@(posedge CLK);
		#2;
		resN = 1'b1;
		busAccess(1'b0, 1'b0, 26'h000_1A2C, 16'h0, got);
		checkValue("data after reset", romWord({1'b0, 24'h00_0D16}), got);
		finishTest();

		$display("tests passed %0d, failed %0d, bound assertion failures %0d",
			passCount, failCount, u_stvCart.u_asserts.assertFails);
		if (failCount == 0 && u_stvCart.u_asserts.assertFails == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* sim/stvCart_asserts.sv */
`timescale 1ns/1ps

module stvCart_asserts #(
	parameter int ROM_ADDR_W = 25
) (
	input logic                  CLK,
	input logic                  RST_N,
	input logic                  resN,
	input logic                  rdN,
	input logic                  memRd,
	input logic                  memRdy,
	input logic [ROM_ADDR_W-1:0] memAddr,
	input logic                  awaitN,
	input logic                  arqtN
);
	int assertFails = 0;

	// level handshake on the memory port
	memHold: assert property (@(posedge CLK) disable iff (!RST_N || !resN)
		memRd && !memRdy |=> memRd && $stable(memAddr))
	else begin
		$error("memRd dropped or memAddr moved before memRdy");
		assertFails++;
	end

	// no strobe for two samples means nothing pending
	idleWait: assert property (@(posedge CLK) disable iff (!RST_N || !resN)
		rdN && $past(rdN) |-> awaitN)
	else begin
		$error("awaitN low with no access pending");
		assertFails++;
	end

	reqInactive: assert property (@(posedge CLK) arqtN)
	else begin
		$error("arqtN went active");
		assertFails++;
	end

	resetQuiet: assert property (@(posedge CLK) (!RST_N || !resN) |=> !memRd && awaitN)
	else begin
		$error("memRd or awaitN active during reset");
		assertFails++;
	end

endmodule

bind stvCart stvCart_asserts #(
	.ROM_ADDR_W(ROM_ADDR_W)
) u_asserts (
	.CLK(CLK),
	.RST_N(RST_N),
	.resN(resN),
	.rdN(rdN),
	.memRd(memRd),
	.memRdy(memRdy),
	.memAddr(memAddr),
	.awaitN(awaitN),
	.arqtN(arqtN)
);

/* src/stvCart.sv */
`timescale 1ns/1ps

module stvCart #(
	parameter int ROM_ADDR_W = 25
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  resN,
	input  cartCfgPkg::gameMode_t mode,
	input  logic                  cs0N,
	input  logic                  cs1N,
	input  logic                  rdN,
	input  logic                  wrlN,
	input  logic                  wruN,
	input  logic [25:0]           addr,
	input  logic [15:0]           dataIn,
	input  logic                  memRdy,
	input  logic [15:0]           memDataIn,
	output logic [15:0]           aDataOut,
	output logic                  awaitN,
	output logic                  arqtN,
	output logic [ROM_ADDR_W-1:0] memAddr,
	output logic                  memRd
);
	import cartBusPkg::*;

	aBusReq_t    req;
	memReq_t     cartReq;
	memReq_t     protReq;
	logic        cartSel;
	logic        protSel;
	logic        cartDone;
	logic        protDone;
	logic        protWaitN;
	logic        directWait;
	logic [15:0] arbData;
	logic [15:0] protData;
	logic [15:0] cartData;

	busStrobeDecoder #(
		.ROM_ADDR_W(ROM_ADDR_W)
	) u_decoder (
		.CLK(CLK),
		.RST_N(RST_N),
		.resN(resN),
		.mode(mode),
		.cs0N(cs0N),
		.cs1N(cs1N),
		.rdN(rdN),
		.wrlN(wrlN),
		.wruN(wruN),
		.addr(addr),
		.dataIn(dataIn),
		.req(req),
		.cartSel(cartSel),
		.protSel(protSel)
	);

	protStreamDecrypt #(
		.ROM_ADDR_W(ROM_ADDR_W)
	) u_prot (
		.CLK(CLK),
		.RST_N(RST_N),
		.resN(resN),
		.mode(mode),
		.req(req),
		.protSel(protSel),
		.fetchDone(protDone),
		.fetchData(arbData),
		.fetchReq(protReq),
		.readData(protData),
		.waitN(protWaitN)
	);

	romReadArbiter #(
		.ROM_ADDR_W(ROM_ADDR_W)
	) u_arbiter (
		.CLK(CLK),
		.RST_N(RST_N),
		.resN(resN),
		.cartReq(cartReq),
		.protReq(protReq),
		.memRdy(memRdy),
		.memDataIn(memDataIn),
		.memAddr(memAddr),
		.memRd(memRd),
		.cartDone(cartDone),
		.protDone(protDone),
		.readData(arbData)
	);

	// direct read pending from pulse to done, new strobes ignored meanwhile
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			directWait <= 1'b0;
		else if (!resN)
			directWait <= 1'b0;
		else if (cartDone)
			directWait <= 1'b0;
		else if (req.rd && cartSel)
			directWait <= 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (cartDone)
			cartData <= arbData;
	end

	// host holds the address during the wait
	always_comb begin
		cartReq.addr = req.wordAddr;
		cartReq.valid = directWait;
	end

	assign awaitN = (!directWait || cartDone) && protWaitN;
	// data from the arbiter is shown in the done cycle already
	assign aDataOut = protSel ? protData : (cartDone ? arbData : cartData);
	assign arqtN = 1'b1;

endmodule

/* src/romReadArbiter.sv */
`timescale 1ns/1ps

module romReadArbiter #(
	parameter int ROM_ADDR_W = 25
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  resN,
	input  cartBusPkg::memReq_t   cartReq,
	input  cartBusPkg::memReq_t   protReq,
	input  logic                  memRdy,
	input  logic [15:0]           memDataIn,
	output logic [ROM_ADDR_W-1:0] memAddr,
	output logic                  memRd,
	output logic                  cartDone,
	output logic                  protDone,
	output logic [15:0]           readData
);
	typedef enum logic {IDLE, BUSY} ownerState_t;

	ownerState_t state;
	logic        ownerProt;
	logic        canGrant;
	logic        grantCart;
	logic        grantProt;
	logic        finish;

	// a requester still shows valid during its done pulse
	assign canGrant = state == IDLE && !cartDone && !protDone;
	// direct reads win a tie
	assign grantCart = canGrant && cartReq.valid;
	assign grantProt = canGrant && protReq.valid && !cartReq.valid;
	assign finish = state == BUSY && memRdy;
	assign memRd = state == BUSY;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= IDLE;
			cartDone <= 1'b0;
			protDone <= 1'b0;
		end else if (!resN) begin
			state <= IDLE;
			cartDone <= 1'b0;
			protDone <= 1'b0;
		end else begin
			cartDone <= finish && !ownerProt;
			protDone <= finish && ownerProt;
			if (grantCart || grantProt)
				state <= BUSY;
			else if (finish)
				state <= IDLE;
		end
	end

	// address held stable for the whole request
	always_ff @(posedge CLK) begin
		if (grantCart) begin
			memAddr <= cartReq.addr[ROM_ADDR_W-1:0];
			ownerProt <= 1'b0;
		end else if (grantProt) begin
			memAddr <= protReq.addr[ROM_ADDR_W-1:0];
			ownerProt <= 1'b1;
		end
		if (finish)
			readData <= memDataIn;
	end

endmodule

/* src/protStreamDecrypt.sv */
`timescale 1ns/1ps

module protStreamDecrypt #(
	parameter int ROM_ADDR_W = 25
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  resN,
	input  cartCfgPkg::gameMode_t mode,
	input  cartBusPkg::aBusReq_t  req,
	input  logic                  protSel,
	input  logic                  fetchDone,
	input  logic [15:0]           fetchData,
	output cartBusPkg::memReq_t   fetchReq,
	output logic [15:0]           readData,
	output logic                  waitN
);
	import cartBusPkg::*;
	import cartCfgPkg::*;

	logic [15:0]           addrLo;
	logic [31:0]           newByteAddr;
	logic [ROM_ADDR_W-1:0] fetchAddr;
	logic [15:0]           bufData;
	logic [31:0]           key;
	logic [15:0]           keyHalf;
	logic                  fetchValid;
	logic                  bufValid;
	logic                  readPend;
	logic                  dropNext;
	logic                  phase;
	logic                  wrLo;
	logic                  wrHi;
	logic                  rdData;
	logic                  got;
	logic                  serveBuf;
	logic                  serveFetch;

	assign key = keyForMode(mode);
	// phase 0 on even stream words
	assign keyHalf = phase ? key[31:16] : key[15:0];
	assign newByteAddr = {req.wrData, addrLo};

	assign wrLo = protSel && req.wr && req.regOff == regAddrLo;
	assign wrHi = protSel && req.wr && req.regOff == regAddrHi;
	assign rdData = protSel && req.rd && req.regOff == regData;

	// a fetch launched before a restart comes back stale
	assign got = fetchDone && !dropNext;
	assign serveBuf = rdData && bufValid;
	assign serveFetch = got && (readPend || rdData);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			fetchValid <= 1'b0;
			bufValid <= 1'b0;
			readPend <= 1'b0;
			dropNext <= 1'b0;
			phase <= 1'b0;
		end else if (!resN) begin
			fetchValid <= 1'b0;
			bufValid <= 1'b0;
			readPend <= 1'b0;
			dropNext <= 1'b0;
			phase <= 1'b0;
		end else if (wrHi) begin
			// restart the stream
			fetchValid <= 1'b1;
			dropNext <= fetchValid && !fetchDone;
			bufValid <= 1'b0;
			readPend <= 1'b0;
			phase <= 1'b0;
		end else begin
			if (fetchDone && dropNext)
				dropNext <= 1'b0;
			if (serveBuf || serveFetch) begin
				// word consumed, prefetch the next one
				phase <= !phase;
				fetchValid <= 1'b1;
				bufValid <= 1'b0;
				readPend <= 1'b0;
			end else if (got) begin
				bufValid <= 1'b1;
				fetchValid <= 1'b0;
			end else if (rdData) begin
				readPend <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wrLo)
			addrLo <= req.wrData;
		if (wrHi)
			fetchAddr <= newByteAddr[ROM_ADDR_W:1];
		else if (got)
			fetchAddr <= fetchAddr + 1'b1;
		if (got)
			bufData <= fetchData;
		if (serveBuf)
			readData <= bufData ^ keyHalf;
		else if (serveFetch)
			readData <= fetchData ^ keyHalf;
	end

	always_comb begin
		fetchReq = '0;
		fetchReq.addr[ROM_ADDR_W-1:0] = fetchAddr;
		fetchReq.valid = fetchValid;
	end

	// low only while a data read waits for its word
	assign waitN = !readPend;

endmodule

/* src/busStrobeDecoder.sv */
`timescale 1ns/1ps

module busStrobeDecoder #(
	parameter int ROM_ADDR_W = 25
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  resN,
	input  cartCfgPkg::gameMode_t mode,
	input  logic                  cs0N,
	input  logic                  cs1N,
	input  logic                  rdN,
	input  logic                  wrlN,
	input  logic                  wruN,
	input  logic [25:0]           addr,
	input  logic [15:0]           dataIn,
	output cartBusPkg::aBusReq_t  req,
	output logic                  cartSel,
	output logic                  protSel
);
	import cartBusPkg::*;
	import cartCfgPkg::*;

	logic                 rdOld;
	logic                 wrOld;
	logic                 wrN;
	logic                 protHit;
	logic [cartAddrW-1:0] wordAddr;

	assign wrN = wrlN & wruN;
	// top 16 bytes of CS1, only when the game has a key
	assign protHit = !cs1N && addr[23:1] >= protWindowBase && keyForMode(mode) != '0;

	always_comb begin
		wordAddr = '0;
		// CS0 active means the lower half of the ROM
		wordAddr[ROM_ADDR_W-1:0] = {cs0N, addr[ROM_ADDR_W-1:1]};
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdOld <= 1'b1;
			wrOld <= 1'b1;
			req <= '0;
			cartSel <= 1'b0;
			protSel <= 1'b0;
		end else if (!resN) begin
			rdOld <= 1'b1;
			wrOld <= 1'b1;
			req <= '0;
			cartSel <= 1'b0;
			protSel <= 1'b0;
		end else begin
			rdOld <= rdN;
			wrOld <= wrN;
			// falling strobe edges
			req.rd <= !rdN && rdOld;
			req.wr <= !wrN && wrOld;
			req.wordAddr <= wordAddr;
			req.regOff <= addr[3:1];
			req.wrData <= dataIn;
			cartSel <= (!cs0N || !cs1N) && !protHit;
			protSel <= protHit;
		end
	end

endmodule

/* src/cartCfgPkg.sv */
package cartCfgPkg;

	// 0 selects a cart without protection
	typedef logic [3:0] gameMode_t;

	// per-game stream key, lower half for even words
	function automatic logic [31:0] keyForMode(input gameMode_t mode);
		case (mode)
			4'd1: return 32'h1C5A_3E07;
			4'd2: return 32'h2B91_D046;
			4'd3: return 32'h37E4_8A15;
			4'd4: return 32'h4D02_F36B;
			4'd5: return 32'h5A6C_1B98;
			4'd6: return 32'h63F7_25C1;
			// unused modes behave like an unprotected cart
			default: return 32'h0000_0000;
		endcase
	endfunction

endpackage

/* src/cartBusPkg.sv */
package cartBusPkg;

	// word address width on the cart side, CS bit included
	localparam int cartAddrW = 25;

	// word offset of the protection window inside the CS1 space
	// covers byte offsets 0xFFFFF0 to 0xFFFFFF
	localparam logic [22:0] protWindowBase = 23'h7F_FFF8;

	// protection register offsets, A-bus address bits 3:1
	localparam logic [2:0] regAddrLo = 3'd0;
	localparam logic [2:0] regAddrHi = 3'd1;
	localparam logic [2:0] regData = 3'd2;

	// one decoded A-bus access, pulses last a single cycle
	typedef struct packed {
		logic [cartAddrW-1:0] wordAddr;
		logic [15:0]          wrData;
		logic [2:0]           regOff;
		logic                 rd;
		logic                 wr;
	} aBusReq_t;

	// one request toward the memory read port
	typedef struct packed {
		logic [cartAddrW-1:0] addr;
		logic                 valid;
	} memReq_t;

endpackage
